//--- little_pkg.sv
package little_pkg;

    // Datapath widths
    localparam int WORD_WIDTH     = 16;
    localparam int BYTE_WIDTH     = 8;
    localparam int SEG_WIDTH      = 8;
    localparam int MEM_ADDR_WIDTH = 8;
    localparam int MEM_DEPTH      = 1 << MEM_ADDR_WIDTH;

    // UART timing, sysclk cycles per serial bit
    localparam int CLKS_PER_BIT = 16;

    // Stand-in for the SDRAM power-up sequence
    localparam int MEM_INIT_CYCLES = 64;

    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [BYTE_WIDTH-1:0]     byte_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [WORD_WIDTH-1:0]     load_count_t;

    // dp, g .. a, all active low
    typedef logic [SEG_WIDTH-1:0]      hex_seg_t;

    // One request on a memory port, req_valid is a single-cycle strobe
    typedef struct packed {
        logic      req_valid;
        logic      write_en;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    typedef enum logic {
        BOOT_WAIT_MEM,
        BOOT_RUN
    } boot_state_e;

endpackage

//--- uart_rx.sv
`timescale 1ns/1ps

module uart_rx
    import little_pkg::*;
(
    input  logic  sysclk,
    input  logic  sysrst,
    input  logic  rx,
    output logic  byte_valid,
    output byte_t rx_byte
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e                           state;
    logic [1:0]                          rx_sync;
    logic                                rx_prev;
    logic [$clog2(CLKS_PER_BIT)-1:0]     baud_cnt;
    logic [$clog2(BYTE_WIDTH)-1:0]       bit_idx;
    byte_t                               shift_reg;
    logic                                start_edge;

    // Line idles high, start bit pulls it low
    assign start_edge = rx_prev & ~rx_sync[1];

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_prev <= rx_sync[1];
        end
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            state      <= RX_IDLE;
            baud_cnt   <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                // Wait half a bit to land in the middle of the start bit
                RX_START: begin
                    if (baud_cnt == CLKS_PER_BIT / 2 - 1) begin
                        baud_cnt <= '0;
                        // Glitch, not a real start bit
                        state    <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (baud_cnt == CLKS_PER_BIT - 1) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == BYTE_WIDTH - 1) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (baud_cnt == CLKS_PER_BIT - 1) begin
                        baud_cnt   <= '0;
                        state      <= RX_IDLE;
                        // Framing error drops the byte
                        byte_valid <= rx_sync[1];
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge sysclk) begin
        if (state == RX_DATA && baud_cnt == CLKS_PER_BIT - 1) begin
            shift_reg <= {rx_sync[1], shift_reg[BYTE_WIDTH-1:1]};
        end
    end

    always_ff @(posedge sysclk) begin
        if (state == RX_STOP && baud_cnt == CLKS_PER_BIT - 1) begin
            rx_byte <= shift_reg;
        end
    end

endmodule

//--- uart_word_asm.sv
`timescale 1ns/1ps

module uart_word_asm
    import little_pkg::*;
(
    input  logic  sysclk,
    input  logic  sysrst,
    input  logic  byte_valid,
    input  byte_t rx_byte,
    output logic  word_valid,
    output word_t rx_word
);

    // High while the low byte is held and the high byte is awaited
    logic  high_phase;
    byte_t low_byte;

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            high_phase <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;
            if (byte_valid) begin
                high_phase <= ~high_phase;
                word_valid <= high_phase;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (byte_valid && !high_phase) begin
            low_byte <= rx_byte;
        end
    end

    always_ff @(posedge sysclk) begin
        if (byte_valid && high_phase) begin
            rx_word <= {rx_byte, low_byte};
        end
    end

endmodule

//--- boot_loader.sv
`timescale 1ns/1ps

module boot_loader
    import little_pkg::*;
(
    input  logic        sysclk,
    input  logic        sysrst,
    input  logic        load_en,
    input  logic        word_valid,
    input  word_t       rx_word,
    input  logic        mem_ready,
    output mem_req_t    load_req,
    output logic        load_active,
    output load_count_t load_count,
    output logic        cpu_run
);

    boot_state_e state;
    logic [1:0]  load_sync;
    logic        load_prev;
    logic        load_rise;

    assign load_active = load_sync[1];
    assign load_rise   = load_sync[1] & ~load_prev;

    // Switch is asynchronous to sysclk
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            load_sync <= 2'b00;
            load_prev <= 1'b0;
        end else begin
            load_sync <= {load_sync[0], load_en};
            load_prev <= load_sync[1];
        end
    end

    // Word counter doubles as the write address
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            load_count         <= '0;
            load_req.req_valid <= 1'b0;
        end else begin
            load_req.req_valid <= 1'b0;
            if (load_rise) begin
                load_count <= '0;
            end else if (word_valid && load_active) begin
                load_count         <= load_count + 1'b1;
                load_req.req_valid <= 1'b1;
                load_req.write_en  <= 1'b1;
                load_req.addr      <= load_count[MEM_ADDR_WIDTH-1:0];
                load_req.wdata     <= rx_word;
            end
        end
    end

    // Hold the CPU until memory init is done, then run for good
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            state <= BOOT_WAIT_MEM;
        end else begin
            case (state)
                BOOT_WAIT_MEM: if (mem_ready) state <= BOOT_RUN;
                BOOT_RUN:      state <= BOOT_RUN;
                default:       state <= BOOT_WAIT_MEM;
            endcase
        end
    end

    assign cpu_run = (state == BOOT_RUN);

endmodule

//--- word_mem.sv
`timescale 1ns/1ps

module word_mem
    import little_pkg::*;
(
    input  logic     sysclk,
    input  logic     sysrst,
    input  logic     load_active,
    input  mem_req_t load_req,
    input  mem_req_t cpu_req,
    output logic     mem_ready,
    output word_t    cpu_rdata,
    output logic     cpu_rvalid
);

    word_t                              mem_array [MEM_DEPTH];
    logic [$clog2(MEM_INIT_CYCLES)-1:0] init_cnt;
    mem_req_t                           sel_req;
    logic                               do_write;
    logic                               do_read;

    // Loader owns the port while the load switch is on
    always_comb begin
        sel_req = load_active ? load_req : cpu_req;
    end

    assign do_write = mem_ready && sel_req.req_valid && sel_req.write_en;

    // Reads only ever come from the CPU side
    assign do_read = mem_ready && !load_active && cpu_req.req_valid && !cpu_req.write_en;

    // Startup delay, mimics SDRAM init
    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            init_cnt  <= '0;
            mem_ready <= 1'b0;
        end else if (!mem_ready) begin
            if (init_cnt == MEM_INIT_CYCLES - 1) begin
                mem_ready <= 1'b1;
            end else begin
                init_cnt <= init_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (do_write) begin
            mem_array[sel_req.addr] <= sel_req.wdata;
        end
    end

    // rdata holds until the next read
    always_ff @(posedge sysclk) begin
        if (do_read) begin
            cpu_rdata <= mem_array[cpu_req.addr];
        end
    end

    always_ff @(posedge sysclk) begin
        if (!sysrst) begin
            cpu_rvalid <= 1'b0;
        end else begin
            cpu_rvalid <= do_read;
        end
    end

endmodule

//--- hex_display.sv
`timescale 1ns/1ps

module hex_display
    import little_pkg::*;
(
    input  word_t    value,
    output hex_seg_t hex0,
    output hex_seg_t hex1,
    output hex_seg_t hex2,
    output hex_seg_t hex3
);

    // Bit 7 is the decimal point, kept dark
    function automatic hex_seg_t nibble_to_seg(input logic [3:0] nibble);
        hex_seg_t seg;
        case (nibble)
            4'h0:    seg = 8'hC0;
            4'h1:    seg = 8'hF9;
            4'h2:    seg = 8'hA4;
            4'h3:    seg = 8'hB0;
            4'h4:    seg = 8'h99;
            4'h5:    seg = 8'h92;
            4'h6:    seg = 8'h82;
            4'h7:    seg = 8'hF8;
            4'h8:    seg = 8'h80;
            4'h9:    seg = 8'h90;
            4'hA:    seg = 8'h88;
            4'hB:    seg = 8'h83;
            4'hC:    seg = 8'hC6;
            4'hD:    seg = 8'hA1;
            4'hE:    seg = 8'h86;
            default: seg = 8'h8E;
        endcase
        return seg;
    endfunction

    assign hex0 = nibble_to_seg(value[3:0]);
    assign hex1 = nibble_to_seg(value[7:4]);
    assign hex2 = nibble_to_seg(value[11:8]);
    assign hex3 = nibble_to_seg(value[15:12]);

endmodule

//--- little_computer_core.sv
`timescale 1ns/1ps

module little_computer_core
    import little_pkg::*;
(
    input  logic     sysclk,
    input  logic     sysrst,
    input  logic     rx,
    input  logic     load_en,
    input  mem_req_t cpu_req,
    output word_t    cpu_rdata,
    output logic     cpu_rvalid,
    output logic     cpu_run,
    output hex_seg_t hex0,
    output hex_seg_t hex1,
    output hex_seg_t hex2,
    output hex_seg_t hex3
);

    logic        byte_valid;
    byte_t       rx_byte;
    logic        word_valid;
    word_t       rx_word;
    mem_req_t    load_req;
    logic        load_active;
    logic        mem_ready;
    load_count_t load_count;

    uart_rx u_uart_rx (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .rx         (rx),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte)
    );

    uart_word_asm u_uart_word_asm (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .word_valid (word_valid),
        .rx_word    (rx_word)
    );

    boot_loader u_boot_loader (
        .sysclk      (sysclk),
        .sysrst      (sysrst),
        .load_en     (load_en),
        .word_valid  (word_valid),
        .rx_word     (rx_word),
        .mem_ready   (mem_ready),
        .load_req    (load_req),
        .load_active (load_active),
        .load_count  (load_count),
        .cpu_run     (cpu_run)
    );

    word_mem u_word_mem (
        .sysclk      (sysclk),
        .sysrst      (sysrst),
        .load_active (load_active),
        .load_req    (load_req),
        .cpu_req     (cpu_req),
        .mem_ready   (mem_ready),
        .cpu_rdata   (cpu_rdata),
        .cpu_rvalid  (cpu_rvalid)
    );

    // Shows the number of loaded words
    hex_display u_hex_display (
        .value (load_count),
        .hex0  (hex0),
        .hex1  (hex1),
        .hex2  (hex2),
        .hex3  (hex3)
    );

endmodule

//--- tb_little_computer.sv
`timescale 1ns/1ps

module tb_little_computer
    import little_pkg::*;
();

    localparam int SETTLE_CYCLES = 64;
    localparam int RUN_TIMEOUT   = MEM_INIT_CYCLES + 16;

    logic     sysclk;
    logic     sysrst;
    logic     rx;
    logic     load_en;
    mem_req_t cpu_req;
    word_t    cpu_rdata;
    logic     cpu_rvalid;
    logic     cpu_run;
    hex_seg_t hex0;
    hex_seg_t hex1;
    hex_seg_t hex2;
    hex_seg_t hex3;

    // Expected memory contents and loaded-word count
    word_t       model_mem [MEM_DEPTH];
    load_count_t model_count;
    hex_seg_t    seg_table [16];
    string       test_name;

    little_computer_core dut (
        .sysclk     (sysclk),
        .sysrst     (sysrst),
        .rx         (rx),
        .load_en    (load_en),
        .cpu_req    (cpu_req),
        .cpu_rdata  (cpu_rdata),
        .cpu_rvalid (cpu_rvalid),
        .cpu_run    (cpu_run),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3)
    );

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    // Inputs change 5 ns after the rising edge
    task automatic next_cycle();
        @(posedge sysclk);
        #5;
    endtask

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: %s expected %h actual %h", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_seg(input string what, input hex_seg_t expected,
                             input hex_seg_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: %s expected %h actual %h", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: %s expected %b actual %b", test_name, what, expected, actual);
            abort_run();
        end
    endtask

    // Active low with the decimal point dark
    task automatic init_seg_table();
        seg_table[0]  = 8'hC0;
        seg_table[1]  = 8'hF9;
        seg_table[2]  = 8'hA4;
        seg_table[3]  = 8'hB0;
        seg_table[4]  = 8'h99;
        seg_table[5]  = 8'h92;
        seg_table[6]  = 8'h82;
        seg_table[7]  = 8'hF8;
        seg_table[8]  = 8'h80;
        seg_table[9]  = 8'h90;
        seg_table[10] = 8'h88;
        seg_table[11] = 8'h83;
        seg_table[12] = 8'hC6;
        seg_table[13] = 8'hA1;
        seg_table[14] = 8'h86;
        seg_table[15] = 8'h8E;
    endtask

    function automatic logic display_shows(input load_count_t count);
        return hex0 === seg_table[count[3:0]] && hex1 === seg_table[count[7:4]] &&
               hex2 === seg_table[count[11:8]] && hex3 === seg_table[count[15:12]];
    endfunction

    task automatic check_display(input load_count_t count);
        check_seg("hex0", seg_table[count[3:0]], hex0);
        check_seg("hex1", seg_table[count[7:4]], hex1);
        check_seg("hex2", seg_table[count[11:8]], hex2);
        check_seg("hex3", seg_table[count[15:12]], hex3);
    endtask

    task automatic wait_display(input load_count_t count);
        int cycles;
        cycles = 0;
        while (cycles < SETTLE_CYCLES && !display_shows(count)) begin
            next_cycle();
            cycles++;
        end
        check_display(count);
    endtask

    task automatic wait_cpu_run();
        int cycles;
        cycles = 0;
        while (!cpu_run && cycles < RUN_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        if (!cpu_run) begin
            $display("Timeout: cpu_run did not rise within %0d cycles of reset", RUN_TIMEOUT);
            abort_run();
        end
    endtask

    // 8N1 frame with the LSB first
    task automatic uart_send_byte(input byte_t b);
        rx = 1'b0;
        repeat (CLKS_PER_BIT) next_cycle();
        for (int i = 0; i < BYTE_WIDTH; i++) begin
            rx = b[i];
            repeat (CLKS_PER_BIT) next_cycle();
        end
        rx = 1'b1;
        repeat (CLKS_PER_BIT) next_cycle();
    endtask

    task automatic uart_send_word(input word_t w);
        uart_send_byte(w[7:0]);
        uart_send_byte(w[15:8]);
        // Idle line between words
        repeat (CLKS_PER_BIT) next_cycle();
    endtask

    task automatic load_words(input int count);
        word_t w;
        for (int i = 0; i < count; i++) begin
            w = word_t'($urandom);
            uart_send_word(w);
            model_mem[model_count[MEM_ADDR_WIDTH-1:0]] = w;
            model_count++;
        end
    endtask

    // Two-flop synchronizer plus edge detect settle within four cycles
    task automatic set_load_switch(input logic on);
        load_en = on;
        repeat (4) next_cycle();
        if (on) begin
            model_count = '0;
        end
    endtask

    task automatic cpu_write(input mem_addr_t addr, input word_t data);
        cpu_req.req_valid = 1'b1;
        cpu_req.write_en  = 1'b1;
        cpu_req.addr      = addr;
        cpu_req.wdata     = data;
        next_cycle();
        cpu_req.req_valid = 1'b0;
        cpu_req.write_en  = 1'b0;
    endtask

    task automatic cpu_read(input mem_addr_t addr, output word_t data, output logic valid);
        cpu_req.req_valid = 1'b1;
        cpu_req.write_en  = 1'b0;
        cpu_req.addr      = addr;
        cpu_req.wdata     = '0;
        next_cycle();
        cpu_req.req_valid = 1'b0;
        valid = cpu_rvalid;
        data  = cpu_rdata;
    endtask

    task automatic read_check(input mem_addr_t addr, input word_t expected);
        word_t data;
        logic  valid;
        cpu_read(addr, data, valid);
        check_bit("cpu_rvalid one cycle after read", 1'b1, valid);
        check_word($sformatf("rdata[%0d]", addr), expected, data);
        next_cycle();
        check_bit("cpu_rvalid single cycle", 1'b0, cpu_rvalid);
    endtask

    task automatic test_boot();
        test_name = "boot";
        check_bit("cpu_run after reset", 1'b0, cpu_run);
        check_bit("cpu_rvalid after reset", 1'b0, cpu_rvalid);
        check_display(16'h0000);
        wait_cpu_run();
        repeat (8) begin
            next_cycle();
            check_bit("cpu_run held", 1'b1, cpu_run);
        end
    endtask

    task automatic test_program_load();
        test_name = "program_load";
        set_load_switch(1'b1);
        load_words(20);
        wait_display(16'h0014);
    endtask

    task automatic test_readback();
        test_name = "readback";
        set_load_switch(1'b0);
        check_bit("cpu_run", 1'b1, cpu_run);
        for (int a = 0; a < 20; a++) begin
            read_check(mem_addr_t'(a), model_mem[a]);
        end
    endtask

    task automatic test_cpu_write();
        word_t w;
        test_name = "cpu_write";
        for (int a = 100; a < 110; a++) begin
            w = word_t'($urandom);
            cpu_write(mem_addr_t'(a), w);
            model_mem[a] = w;
        end
        for (int a = 100; a < 110; a++) begin
            read_check(mem_addr_t'(a), model_mem[a]);
        end
    endtask

    task automatic test_port_arbitration();
        word_t data;
        logic  valid;
        test_name = "port_arbitration";
        set_load_switch(1'b1);
        wait_display(16'h0000);
        cpu_read(8'd3, data, valid);
        check_bit("cpu_rvalid while loading", 1'b0, valid);
        repeat (2) begin
            next_cycle();
            check_bit("cpu_rvalid while loading", 1'b0, cpu_rvalid);
        end
        // Loader owns the port so this write is dropped
        cpu_write(8'd105, ~model_mem[105]);
        set_load_switch(1'b0);
        read_check(8'd105, model_mem[105]);
    endtask

    task automatic test_reload();
        test_name = "reload";
        set_load_switch(1'b1);
        wait_display(16'h0000);
        load_words(5);
        wait_display(16'h0005);
        set_load_switch(1'b0);
        for (int a = 0; a < 20; a++) begin
            read_check(mem_addr_t'(a), model_mem[a]);
        end
    endtask

    initial begin
        void'($urandom(12412));
        sysrst      = 1'b0;
        rx          = 1'b1;
        load_en     = 1'b0;
        cpu_req     = '0;
        model_count = '0;
        test_name   = "reset";
        init_seg_table();
        repeat (16) next_cycle();
        sysrst = 1'b1;
        next_cycle();

        test_boot();
        test_program_load();
        test_readback();
        test_cpu_write();
        test_reload();
        test_port_arbitration();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- sim.f
little_pkg.sv
uart_rx.sv
uart_word_asm.sv
boot_loader.sv
word_mem.sv
hex_display.sv
little_computer_core.sv
tb_little_computer.sv
